/* axi_lite_regs.f */
+incdir+include
logic/axi_lite_regs_pkg.sv
logic/lite_write_channel.sv
logic/lite_read_channel.sv
logic/reg_bank.sv
logic/axi_lite_regs.sv
tests/axi_lite_regs_assertions.sv
tests/axi_lite_regs_tb.sv

/* include/axi_lite_regs_defs.svh */
`ifndef AXI_LITE_REGS_DEFS_SVH
`define AXI_LITE_REGS_DEFS_SVH

// Bus geometry
`define DATA_WIDTH 32                   // One bus word
`define STRB_WIDTH (`DATA_WIDTH / 8)    // One strobe bit per byte
`define ADDR_WIDTH 7                    // Byte address over 32 words
`define REG_INDEX_WIDTH 5               // Word index, addr[6:2]

// Register map
`define WRITABLE_REGS 16                // Indices 0 to 15
`define MIRROR_BASE 16                  // First read-only mirror
`define MIRROR_SRC 2                    // Mirror 16 shows reg 2
`define MIRROR_COUNT 10                 // Mirrors 16 to 25
`define SUM0_INDEX 26                   // Reg 12 + reg 13
`define SUM1_INDEX 27                   // Reg 14 + reg 15

// Response codes
`define RESP_OKAY 2'b00

`endif

/* logic/axi_lite_regs.sv */
`timescale 1ns/100ps
`include "axi_lite_regs_defs.svh"

module axi_lite_regs (
  input  logic                           aclk,
  input  logic                           rst,
  input  axi_lite_regs_pkg::addr_beat_t  aw,
  input  logic                           awvalid,
  output logic                           awready,
  input  axi_lite_regs_pkg::wdata_beat_t w,
  input  logic                           wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  axi_lite_regs_pkg::addr_beat_t  ar,
  input  logic                           arvalid,
  output logic                           arready,
  output axi_lite_regs_pkg::rresp_beat_t r,
  output logic                           rvalid,
  input  logic                           rready
);

  axi_lite_regs_pkg::wr_cmd_t  wr_cmd;     // Write channel to bank
  logic                        wr_en;
  logic [`REG_INDEX_WIDTH-1:0] rd_index;   // Read channel to bank
  logic [`DATA_WIDTH-1:0]      rd_data;    // Bank to read channel

  lite_write_channel write_ch_i (
    .aclk    (aclk),
    .rst     (rst),
    .aw      (aw),
    .awvalid (awvalid),
    .awready (awready),
    .w       (w),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .wr_cmd  (wr_cmd),
    .wr_en   (wr_en)
  );

  lite_read_channel read_ch_i (
    .aclk     (aclk),
    .rst      (rst),
    .ar       (ar),
    .arvalid  (arvalid),
    .arready  (arready),
    .rd_index (rd_index),
    .rd_data  (rd_data),
    .r        (r),
    .rvalid   (rvalid),
    .rready   (rready)
  );

  reg_bank bank_i (
    .aclk     (aclk),
    .rst      (rst),
    .wr_cmd   (wr_cmd),
    .wr_en    (wr_en),
    .rd_index (rd_index),
    .rd_data  (rd_data)
  );

endmodule

/* logic/axi_lite_regs_pkg.sv */
`include "axi_lite_regs_defs.svh"

package axi_lite_regs_pkg;

  // AW and AR payload
  typedef struct packed {
    logic [`ADDR_WIDTH-1:0] addr;   // Byte address
    logic [2:0]             prot;   // Accepted, not decoded
  } addr_beat_t;

  // W payload, also carried in the write command
  typedef struct packed {
    logic [`DATA_WIDTH-1:0] data;
    logic [`STRB_WIDTH-1:0] strb;   // Byte enables
  } wdata_beat_t;

  // R payload
  typedef struct packed {
    logic [`DATA_WIDTH-1:0] data;
    logic [1:0]             resp;   // Always OKAY here
  } rresp_beat_t;

  // Write channel to register bank
  typedef struct packed {
    logic [`REG_INDEX_WIDTH-1:0] index;  // Word index
    wdata_beat_t                 wdata;  // Data and strobes
  } wr_cmd_t;

endpackage

/* logic/lite_read_channel.sv */
`timescale 1ns/100ps
`include "axi_lite_regs_defs.svh"

module lite_read_channel (
  input  logic                                aclk,
  input  logic                                rst,
  input  axi_lite_regs_pkg::addr_beat_t       ar,        // AR payload
  input  logic                                arvalid,
  output logic                                arready,
  output logic [`REG_INDEX_WIDTH-1:0]         rd_index,  // To reg bank
  input  logic [`DATA_WIDTH-1:0]              rd_data,   // Decoded word
  output axi_lite_regs_pkg::rresp_beat_t      r,         // R payload
  output logic                                rvalid,
  input  logic                                rready
);

  logic ar_pend;   // Index latched, data sampled next edge
  logic ar_hs;
  logic r_hs;

  assign ar_hs = arvalid & arready;
  assign r_hs  = rvalid & rready;

  // One read in flight at a time
  assign arready = ~ar_pend & ~rvalid;

  always_ff @(posedge aclk) begin
    if (rst) begin
      ar_pend <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      ar_pend <= ar_hs;                     // Single-cycle lookup
      if (ar_pend) begin
        rvalid <= 1'b1;
      end else if (r_hs) begin
        rvalid <= 1'b0;                     // Held until accepted
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (ar_hs) begin
      rd_index <= ar.addr[`ADDR_WIDTH-1:2]; // Word index, prot unused
    end
    if (ar_pend) begin
      r <= '{data: rd_data, resp: `RESP_OKAY};
    end
  end

endmodule

/* logic/lite_write_channel.sv */
`timescale 1ns/100ps
`include "axi_lite_regs_defs.svh"

module lite_write_channel (
  input  logic                           aclk,
  input  logic                           rst,
  input  axi_lite_regs_pkg::addr_beat_t  aw,       // AW payload
  input  logic                           awvalid,
  output logic                           awready,
  input  axi_lite_regs_pkg::wdata_beat_t w,        // W payload
  input  logic                           wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  logic                           bready,
  output axi_lite_regs_pkg::wr_cmd_t     wr_cmd,   // To reg bank
  output logic                           wr_en     // One pulse per write
);

  logic                           aw_full;   // Address slot holds a beat
  logic                           w_full;    // Data slot holds a beat
  logic [`REG_INDEX_WIDTH-1:0]    index_q;   // Word index of held address
  axi_lite_regs_pkg::wdata_beat_t w_q;       // Held data and strobe
  logic                           aw_hs;
  logic                           w_hs;
  logic                           b_hs;

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;
  assign b_hs  = bvalid & bready;

  // Each slot takes one beat, then waits for B to drain
  assign awready = ~aw_full;
  assign wready  = ~w_full;
  assign bresp   = `RESP_OKAY;              // No error paths

  assign wr_cmd = '{index: index_q, wdata: w_q};

  always_ff @(posedge aclk) begin
    if (rst) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      wr_en   <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      if (aw_hs) begin
        aw_full <= 1'b1;
      end else if (b_hs) begin
        aw_full <= 1'b0;                    // Freed by the response
      end
      if (w_hs) begin
        w_full <= 1'b1;
      end else if (b_hs) begin
        w_full <= 1'b0;
      end
      // Fire once when both slots filled, not again until B done
      wr_en <= aw_full & w_full & ~wr_en & ~bvalid;
      if (wr_en) begin
        bvalid <= 1'b1;                     // Same edge as bank write
      end else if (b_hs) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Payload slots
  always_ff @(posedge aclk) begin
    if (aw_hs) begin
      index_q <= aw.addr[`ADDR_WIDTH-1:2];  // Drop byte offset
    end
    if (w_hs) begin
      w_q <= w;
    end
  end

endmodule

/* logic/reg_bank.sv */
`timescale 1ns/100ps
`include "axi_lite_regs_defs.svh"

module reg_bank (
  input  logic                              aclk,
  input  logic                              rst,
  input  axi_lite_regs_pkg::wr_cmd_t        wr_cmd,    // Index, data, strobe
  input  logic                              wr_en,     // Write at this edge
  input  logic [`REG_INDEX_WIDTH-1:0]       rd_index,
  output logic [`DATA_WIDTH-1:0]            rd_data    // Combinational decode
);

  localparam int SEL_W = $clog2(`WRITABLE_REGS);  // Bits to pick a register

  logic [`DATA_WIDTH-1:0] regs [`WRITABLE_REGS];  // Writable bank
  logic [SEL_W-1:0]       wr_sel;
  logic [SEL_W-1:0]       mirror_sel;             // Source reg of a mirror
  logic                   wr_hit;                 // Index inside writable range
  logic                   in_mirror;
  logic [`DATA_WIDTH-1:0] sum0;
  logic [`DATA_WIDTH-1:0] sum1;

  assign wr_sel = wr_cmd.index[SEL_W-1:0];
  assign wr_hit = wr_cmd.index < `WRITABLE_REGS;  // Upper map is read-only

  // Byte-strobed update
  always_ff @(posedge aclk) begin
    if (rst) begin
      for (int i = 0; i < `WRITABLE_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_hit) begin
      for (int b = 0; b < `STRB_WIDTH; b++) begin
        if (wr_cmd.wdata.strb[b]) begin
          regs[wr_sel][8*b +: 8] <= wr_cmd.wdata.data[8*b +: 8];  // Other bytes kept
        end
      end
    end
  end

  // Mirror window maps 16..25 onto 2..11
  assign mirror_sel = SEL_W'(rd_index - `MIRROR_BASE + `MIRROR_SRC);
  assign in_mirror  = (rd_index >= `MIRROR_BASE) &&
                      (rd_index < `MIRROR_BASE + `MIRROR_COUNT);

  assign sum0 = regs[12] + regs[13];              // Carry out dropped
  assign sum1 = regs[14] + regs[15];

  always_comb begin
    rd_data = '0;                                 // 28..31 read zero
    if (rd_index < `WRITABLE_REGS) begin
      rd_data = regs[rd_index[SEL_W-1:0]];
    end else if (in_mirror) begin
      rd_data = regs[mirror_sel];
    end else if (rd_index == `SUM0_INDEX) begin
      rd_data = sum0;
    end else if (rd_index == `SUM1_INDEX) begin
      rd_data = sum1;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module axi_lite_regs_tb \
  -f axi_lite_regs.f -o sim_exe || { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_exe > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "Result: PASS" && exit 0 || \
  { echo "Result: FAIL"; exit 1; }

/* tests/axi_lite_regs_assertions.sv */
`timescale 1ns/100ps

module axi_lite_regs_assertions (
  input logic                           aclk,
  input logic                           rst,
  input axi_lite_regs_pkg::addr_beat_t  aw,
  input logic                           awvalid,
  input logic                           awready,
  input axi_lite_regs_pkg::wdata_beat_t w,
  input logic                           wvalid,
  input logic                           wready,
  input logic                           bvalid,
  input logic                           bready,
  input axi_lite_regs_pkg::addr_beat_t  ar,
  input logic                           arvalid,
  input logic                           arready,
  input axi_lite_regs_pkg::rresp_beat_t r,
  input logic                           rvalid,
  input logic                           rready
);

  int fail_cnt = 0;   // Failed assertion count, read by the testbench

  aw_hold_a: assert property (@(posedge aclk) disable iff (rst)
      awvalid && !awready |=> awvalid && $stable(aw)) else begin
    fail_cnt++;
    $error("AW valid or payload changed before its handshake");
  end
  w_hold_a: assert property (@(posedge aclk) disable iff (rst)
      wvalid && !wready |=> wvalid && $stable(w)) else begin
    fail_cnt++;
    $error("W valid or payload changed before its handshake");
  end
  ar_hold_a: assert property (@(posedge aclk) disable iff (rst)
      arvalid && !arready |=> arvalid && $stable(ar)) else begin
    fail_cnt++;
    $error("AR valid or payload changed before its handshake");
  end
  b_hold_a: assert property (@(posedge aclk) disable iff (rst)
      bvalid && !bready |=> bvalid) else begin   // bresp is tied to OKAY
    fail_cnt++;
    $error("B valid dropped before its handshake");
  end
  r_hold_a: assert property (@(posedge aclk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(r)) else begin
    fail_cnt++;
    $error("R valid or payload changed before its handshake");
  end
  busy_a: assert property (@(posedge aclk) disable iff (rst)
      !(bvalid && (awready || wready)) && !(rvalid && arready)) else begin
    fail_cnt++;
    $error("Address or data ready high while a response is pending");
  end
  reset_a: assert property (@(posedge aclk)
      rst |=> !bvalid && !rvalid) else begin   // Responses idle out of reset
    fail_cnt++;
    $error("Response valid high in the cycle after reset");
  end

endmodule

bind axi_lite_regs axi_lite_regs_assertions assert_i (
  .aclk, .rst, .aw, .awvalid, .awready, .w, .wvalid, .wready, .bvalid, .bready,
  .ar, .arvalid, .arready, .r, .rvalid, .rready
);

/* tests/axi_lite_regs_tb.sv */
`timescale 1ns/100ps
`include "axi_lite_regs_defs.svh"

module axi_lite_regs_tb;

  localparam int   CLK_PERIOD   = 40;
  localparam int   DRIVE_DLY    = 2;                        // Input skew after the edge
  localparam int   RESET_CYCLES = 4;
  localparam int   NUM_TESTS    = 63;
  localparam int   CYCLE_LIMIT  = RESET_CYCLES + 24 * NUM_TESTS;
  localparam logic OP_WR        = 1'b1;
  localparam logic OP_RD        = 1'b0;

  typedef struct packed {
    logic [8*12-1:0]        name;       // ASCII test name
    logic                   op;
    logic [`ADDR_WIDTH-1:0] addr;       // Byte address
    logic [`DATA_WIDTH-1:0] data;
    logic [`STRB_WIDTH-1:0] strb;
    int                     w_ofs;      // W cycles after AW, negative sends W first
    logic [`DATA_WIDTH-1:0] exp_data;   // Expected read word
  } entry_t;

  logic                           aclk;
  logic                           rst;
  axi_lite_regs_pkg::addr_beat_t  aw;
  logic                           awvalid;
  logic                           awready;
  axi_lite_regs_pkg::wdata_beat_t w;
  logic                           wvalid;
  logic                           wready;
  logic [1:0]                     bresp;
  logic                           bvalid;
  logic                           bready;
  axi_lite_regs_pkg::addr_beat_t  ar;
  logic                           arvalid;
  logic                           arready;
  axi_lite_regs_pkg::rresp_beat_t r;
  logic                           rvalid;
  logic                           rready;

  entry_t      tbl [NUM_TESTS];
  int          n_entries;
  int          cycle_cnt;   // Rising edges so far
  logic [31:0] rnd_state;   // Back-pressure source

  axi_lite_regs dut_i (.*);

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge aclk);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("Run timed out after %0d cycles before the table finished", cycle_cnt);
    $display("Testbench failed");
    $fatal(1, "Timeout");
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: test %s expected 0x%08h actual 0x%08h", test_name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "Mismatch in %s", test_name);
    end
  endtask

  task automatic add_entry(input logic [8*12-1:0] name, input logic op,
                           input logic [`ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int w_ofs, input logic [31:0] exp_data);
    tbl[n_entries] = '{name, op, addr, data, strb, w_ofs, exp_data};
    n_entries = n_entries + 1;
  endtask

  // One clock, then past the drive skew where DUT outputs are settled
  task automatic next_cycle();
    @(posedge aclk);
    #DRIVE_DLY;
  endtask

  task automatic run_write(input string nm, input entry_t e);
    int aw_at;
    int w_at;
    int start;
    int last_hs;
    bit aw_done;
    bit w_done;
    bit aw_fire;
    bit w_fire;
    bit b_fire;
    bit b_seen;
    aw_at   = (e.w_ofs < 0) ? -e.w_ofs : 0;       // W leads by the offset
    w_at    = (e.w_ofs > 0) ? e.w_ofs : 0;
    start   = cycle_cnt;
    last_hs = 0;
    aw_done = 1'b0;
    w_done  = 1'b0;
    b_fire  = 1'b0;
    b_seen  = 1'b0;
    while (!b_fire) begin
      if (!aw_done && cycle_cnt - start >= aw_at) begin
        aw      = '{addr: e.addr, prot: 3'b000};
        awvalid = 1'b1;
      end
      if (!w_done && cycle_cnt - start >= w_at) begin
        w      = '{data: e.data, strb: e.strb};
        wvalid = 1'b1;
      end
      rnd_state = xorshift32(rnd_state);
      bready    = rnd_state[3];
      aw_fire   = awvalid && awready;           // Readies are stable until the edge
      w_fire    = wvalid && wready;
      b_fire    = bvalid && bready;
      if (b_fire) begin
        check_value({nm, "_bresp"}, 32'(`RESP_OKAY), 32'(bresp));
      end
      next_cycle();
      if (aw_fire) begin
        awvalid = 1'b0;
        aw_done = 1'b1;
        last_hs = cycle_cnt;
      end
      if (w_fire) begin
        wvalid  = 1'b0;
        w_done  = 1'b1;
        last_hs = cycle_cnt;
      end
      if (bvalid && !b_seen && !b_fire) begin
        b_seen = 1'b1;
        check_value({nm, "_bdelay"}, 32'd2, 32'(cycle_cnt - last_hs));  // Later beat + 2
      end
    end
    bready = 1'b0;
    check_value({nm, "_bdrop"}, 32'd0, 32'(bvalid));   // One response per write
  endtask

  task automatic run_read(input string nm, input entry_t e);
    int ar_edge;
    bit ar_fire;
    bit r_fire;
    bit r_seen;
    ar      = '{addr: e.addr, prot: 3'b010};   // prot has no effect
    arvalid = 1'b1;
    ar_edge = 0;
    r_fire  = 1'b0;
    r_seen  = 1'b0;
    while (!r_fire) begin
      rnd_state = xorshift32(rnd_state);
      rready    = rnd_state[3];
      ar_fire   = arvalid && arready;
      r_fire    = rvalid && rready;
      if (r_fire) begin
        check_value(nm, e.exp_data, r.data);
        check_value({nm, "_rresp"}, 32'(`RESP_OKAY), 32'(r.resp));
      end
      next_cycle();
      if (ar_fire) begin
        arvalid = 1'b0;
        ar_edge = cycle_cnt;
      end
      if (rvalid && !r_seen && !r_fire) begin
        r_seen = 1'b1;
        check_value({nm, "_rdelay"}, 32'd1, 32'(cycle_cnt - ar_edge));
      end
    end
    rready = 1'b0;
  endtask

  initial begin
    string nm;
    rst       = 1'b1;
    aw        = '0;
    awvalid   = 1'b0;
    w         = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    ar        = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    rnd_state = 32'hff2c_adb4;
    n_entries = 0;
    add_entry("rst_rd0",    OP_RD, 7'h00, 32'h0, 4'h0, 0, 32'h0000_0000);
    add_entry("rst_rd15",   OP_RD, 7'h3c, 32'h0, 4'h0, 0, 32'h0000_0000);
    add_entry("rst_rd26",   OP_RD, 7'h68, 32'h0, 4'h0, 0, 32'h0000_0000);
    add_entry("rst_rd31",   OP_RD, 7'h7c, 32'h0, 4'h0, 0, 32'h0000_0000);
    for (int i = 0; i < `WRITABLE_REGS; i++) begin   // Reg i gets 0x01010101 * (i + 1)
      add_entry("wr_full", OP_WR, 7'(4 * i), 32'h0101_0101 * 32'(i + 1), 4'hf,
                (i % 5) - 2, 32'h0);
    end
    for (int i = 0; i < `WRITABLE_REGS; i++) begin   // Every register reads its word back
      add_entry("rd_full", OP_RD, 7'(4 * i), 32'h0, 4'h0, 0,
                32'h0101_0101 * 32'(i + 1));
    end
    add_entry("rd_mir16",   OP_RD, 7'h40, 32'h0, 4'h0, 0, 32'h0303_0303);  // Reg 2
    add_entry("rd_mir20",   OP_RD, 7'h50, 32'h0, 4'h0, 0, 32'h0707_0707);  // Reg 6
    add_entry("rd_mir25",   OP_RD, 7'h64, 32'h0, 4'h0, 0, 32'h0c0c_0c0c);  // Reg 11
    add_entry("rd_sum26",   OP_RD, 7'h68, 32'h0, 4'h0, 0, 32'h1b1b_1b1b);
    add_entry("rd_sum27",   OP_RD, 7'h6c, 32'h0, 4'h0, 0, 32'h1f1f_1f1f);
    add_entry("wr_strb1",   OP_WR, 7'h0c, 32'hdead_beef, 4'h1, 1, 32'h0);
    add_entry("rd_strb1",   OP_RD, 7'h0c, 32'h0, 4'h0, 0, 32'h0404_04ef);
    add_entry("wr_strb2",   OP_WR, 7'h0c, 32'h1234_5678, 4'ha, -1, 32'h0);
    add_entry("rd_strb2",   OP_RD, 7'h0c, 32'h0, 4'h0, 0, 32'h1204_56ef);
    add_entry("rd_mir17",   OP_RD, 7'h44, 32'h0, 4'h0, 0, 32'h1204_56ef);  // Reg 3
    add_entry("wr_strb0",   OP_WR, 7'h10, 32'hffff_ffff, 4'h0, 0, 32'h0);
    add_entry("rd_strb0",   OP_RD, 7'h10, 32'h0, 4'h0, 0, 32'h0505_0505);
    add_entry("wr_r12",     OP_WR, 7'h30, 32'hffff_fff0, 4'hf, 2, 32'h0);
    add_entry("wr_r13",     OP_WR, 7'h34, 32'h0000_0020, 4'hf, -2, 32'h0);
    add_entry("rd_carry26", OP_RD, 7'h68, 32'h0, 4'h0, 0, 32'h0000_0010);  // Carry dropped
    add_entry("wr_r14",     OP_WR, 7'h38, 32'h8000_0000, 4'hf, 0, 32'h0);
    add_entry("wr_r15",     OP_WR, 7'h3c, 32'h8000_0001, 4'hf, 1, 32'h0);
    add_entry("rd_carry27", OP_RD, 7'h6c, 32'h0, 4'h0, 0, 32'h0000_0001);
    add_entry("wr_a28",     OP_WR, 7'h70, 32'hcafe_f00d, 4'hf, 0, 32'h0);
    add_entry("wr_a31",     OP_WR, 7'h7c, 32'h1234_5678, 4'hf, -1, 32'h0);
    add_entry("wr_a26",     OP_WR, 7'h68, 32'hffff_ffff, 4'hf, 2, 32'h0);
    add_entry("rd_a28",     OP_RD, 7'h70, 32'h0, 4'h0, 0, 32'h0000_0000);
    add_entry("rd_a31",     OP_RD, 7'h7c, 32'h0, 4'h0, 0, 32'h0000_0000);
    add_entry("rd_a26",     OP_RD, 7'h68, 32'h0, 4'h0, 0, 32'h0000_0010);
    add_entry("rd_reg12",   OP_RD, 7'h30, 32'h0, 4'h0, 0, 32'hffff_fff0);  // 28 not aliased
    add_entry("rd_reg15b",  OP_RD, 7'h3c, 32'h0, 4'h0, 0, 32'h8000_0001);  // 31 not aliased
    add_entry("rd_reg10",   OP_RD, 7'h28, 32'h0, 4'h0, 0, 32'h0b0b_0b0b);  // 26 not aliased
    repeat (RESET_CYCLES) @(posedge aclk);
    #DRIVE_DLY;
    rst = 1'b0;
    for (int i = 0; i < n_entries; i++) begin
      nm = string'(tbl[i].name);
      if (tbl[i].op == OP_WR) begin
        run_write(nm, tbl[i]);
      end else begin
        run_read(nm, tbl[i]);
      end
    end
    next_cycle();
    if (dut_i.assert_i.fail_cnt != 0) begin
      $display("Testbench failed");
      $fatal(1, "%0d handshake assertions failed", dut_i.assert_i.fail_cnt);
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule
